// File: verilog/dma_cfg_pkg.sv
// default sizes for the object DMA
// the top level may override both through its own parameters
`default_nettype none

package dma_cfg_pkg;

    // ========================================================================
    // payload
    // ========================================================================

    // width of one object byte as seen on the CPU data bus
    localparam int DEF_DW = 8;

    // ========================================================================
    // transfer length
    // ========================================================================

    // log2 of bytes copied per frame
    // 10 gives the 1024-byte object area of the board
    // the counter carries one extra bit above this as terminal count
    localparam int DEF_LEN_LOG2 = 10;

endpackage

`default_nettype wire

// File: verilog/dma_types_pkg.sv
// enumerations shared by the DMA controller modules
// encodings are fixed widths, 2 bits for state and 1 bit for phase
`default_nettype none

package dma_types_pkg;

    // arbiter FSM
    // idle waits for vblank, request holds busrq_n low until busak,
    // transfer runs the copy, release waits for the CPU to drop busak
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_XFER = 2'd2,
        ST_REL  = 2'd3
    } dma_state_t;

    // slot sequencer phase
    // read phase lets the CPU bus settle on the current address,
    // write phase latches the byte and stores it
    typedef enum logic {
        PH_READ  = 1'b0,
        PH_WRITE = 1'b1
    } slot_phase_t;

endpackage

`default_nettype wire

// File: verilog/dma_xfer_if.sv
// control and status between arbiter, slot sequencer and address counter
// no clock inside, all members are driven by clocked logic of the modules
`timescale 1ns/10ps
`default_nettype none

interface dma_xfer_if
    import dma_cfg_pkg::*;
#(
    parameter int LEN_LOG2 = DEF_LEN_LOG2
);
    // one-cycle pulse, zeroes the address counter
    logic                clear;
    // level, copy may proceed
    logic                run;
    // one-cycle pulse, byte written so advance the address
    logic                step;
    // current address into the CPU object area and the object RAM
    logic [LEN_LOG2-1:0] addr;
    // terminal count reached
    logic                done;

    // arbiter side
    modport ctrl (output clear, output run, input done);

    // sequencer side
    modport seq (input run, input done, output step);

    // counter side
    modport cnt (input clear, input step, output addr, output done);

endinterface

`default_nettype wire

// File: verilog/dma_bus_arbiter.sv
// vblank-started bus request, grant and release for the object DMA
// busak is taken as synchronous to clk with no metastability stages
`timescale 1ns/10ps
`default_nettype none

module dma_bus_arbiter
    import dma_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     vb_n,
    input  logic     busak,
    output logic     busrq_n,
    output logic     dma_cs,
    dma_xfer_if.ctrl xfer
);

    dma_state_t state;
    logic       vb_n_q;
    logic       busak_q;
    logic       clear_q;
    logic       vb_fall;

    // falling edge of vertical blank
    assign vb_fall = vb_n_q & ~vb_n;

    // ========================================================================
    // state machine
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            vb_n_q  <= 1'b1;
            busak_q <= 1'b0;
            busrq_n <= 1'b1;
            clear_q <= 1'b0;
        end else begin
            vb_n_q  <= vb_n;
            busak_q <= busak;
            // clear is a single-cycle pulse
            clear_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // only a fresh vblank starts a request
                    if (vb_fall) begin
                        busrq_n <= 1'b0;
                        state   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // grant seen so zero the counter and own the bus
                    if (busak) begin
                        clear_q <= 1'b1;
                        state   <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    // done still shows the last frame while clear is high
                    if (!clear_q && xfer.done) begin
                        busrq_n <= 1'b1;
                        state   <= ST_REL;
                    end
                end
                ST_REL: begin
                    // vblank edges are ignored until the CPU lets go
                    if (!busak) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // chip select follows the registered acknowledge while the bus is ours
    assign dma_cs = busak_q & ((state == ST_XFER) | (state == ST_REL));

    // copy holds off during the clear cycle and if the grant is lost
    assign xfer.run   = (state == ST_XFER) & ~clear_q & busak_q;
    assign xfer.clear = clear_q;

    // once the bus is free chip select only returns after a new request
    a_cs_needs_request : assert property (@(posedge clk) disable iff (!rst_n)
        (busrq_n && !dma_cs) |=> !dma_cs);

endmodule

`default_nettype wire

// File: verilog/dma_slot_seq.sv
// two-tick read/write slot per byte paced by cen and blocked by hblank
// din must be steady on the write tick while the CPU side decodes dm
`timescale 1ns/10ps
`default_nettype none

module dma_slot_seq
    import dma_cfg_pkg::*;
    import dma_types_pkg::*;
#(
    parameter int DW = DEF_DW
)(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cen,
    input  logic          hbd_n,
    input  logic [DW-1:0] din,
    output logic          we,
    output logic [DW-1:0] wdata,
    dma_xfer_if.seq       xfer
);

    slot_phase_t phase;
    logic        step_q;
    logic        tick;

    // ========================================================================
    // slot qualification
    // ========================================================================

    // pixel tick outside hblank while the copy is live
    // a pending step blocks the tick so dm has moved before the next read
    assign tick = cen & hbd_n & xfer.run & ~xfer.done & ~step_q;

    // ========================================================================
    // phase and strobes
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= PH_READ;
            we     <= 1'b0;
            step_q <= 1'b0;
        end else begin
            we     <= 1'b0;
            step_q <= 1'b0;
            if (!xfer.run) begin
                // every frame starts on a read slot
                phase <= PH_READ;
            end else if (tick) begin
                if (phase == PH_READ) begin
                    phase <= PH_WRITE;
                end else begin
                    phase  <= PH_READ;
                    we     <= 1'b1;
                    step_q <= 1'b1;
                end
            end
        end
    end

    // byte capture on the write tick
    always_ff @(posedge clk) begin
        if (tick && phase == PH_WRITE) begin
            wdata <= din;
        end
    end

    // RAM write and address advance are the same event
    assign xfer.step = step_q;

    // the CPU byte must be driven when the write tick captures it
    a_din_known : assert property (@(posedge clk) disable iff (!rst_n)
        (tick && phase == PH_WRITE) |-> !$isunknown(din));

endmodule

`default_nettype wire

// File: verilog/dma_addr_counter.sv
// transfer address counter, one bit wider than the address
// the extra top bit is the terminal-count flag, held until the next clear
`timescale 1ns/10ps
`default_nettype none

module dma_addr_counter
    import dma_cfg_pkg::*;
#(
    parameter int LEN_LOG2 = DEF_LEN_LOG2
)(
    input  logic    clk,
    input  logic    rst_n,
    dma_xfer_if.cnt xfer
);

    // low bits address the object area, top bit marks the end
    logic [LEN_LOG2:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (xfer.clear) begin
            // clear wins over step
            cnt <= '0;
        end else if (xfer.step) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign xfer.addr = cnt[LEN_LOG2-1:0];
    assign xfer.done = cnt[LEN_LOG2];

    // the sequencer must stop at terminal count, else the address wraps
    a_no_step_after_done : assert property (@(posedge clk) disable iff (!rst_n)
        xfer.step |-> !xfer.done);

endmodule

`default_nettype wire

// File: verilog/obj_ram.sv
// object buffer, one DMA write port and one video read port
// read data is registered, a write and read to one address return old data
`timescale 1ns/10ps
`default_nettype none

module obj_ram
    import dma_cfg_pkg::*;
#(
    parameter int DW       = DEF_DW,
    parameter int LEN_LOG2 = DEF_LEN_LOG2
)(
    input  logic                clk,
    input  logic                we,
    input  logic [LEN_LOG2-1:0] waddr,
    input  logic [DW-1:0]       wdata,
    input  logic [LEN_LOG2-1:0] raddr,
    output logic [DW-1:0]       rdata
);

    // one entry per byte of the CPU object area
    logic [DW-1:0] mem [0:(2**LEN_LOG2)-1];

    // DMA side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // video side, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: verilog/popeye_obj_dma.sv
// object DMA top, copies the CPU object area into the sprite buffer at vblank
// single clock, cen marks pixel ticks, din comes from the CPU data bus
`timescale 1ns/10ps
`default_nettype none

module popeye_obj_dma
    import dma_cfg_pkg::*;
#(
    parameter int DW       = DEF_DW,
    parameter int LEN_LOG2 = DEF_LEN_LOG2
)(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  logic                vb_n,
    input  logic                hbd_n,
    input  logic                busak,
    input  logic [DW-1:0]       din,
    input  logic [LEN_LOG2-1:0] obj_raddr,
    output logic                busrq_n,
    output logic                dma_cs,
    output logic [LEN_LOG2-1:0] dm,
    output logic [DW-1:0]       obj_rdata
);

    // ========================================================================
    // control bundle and RAM write port
    // ========================================================================

    dma_xfer_if #(.LEN_LOG2(LEN_LOG2)) xfer_if ();

    logic          ram_we;
    logic [DW-1:0] ram_wdata;

    // the counter address drives both the CPU bus and the RAM write port
    assign dm = xfer_if.addr;

    // ========================================================================
    // blocks
    // ========================================================================

    dma_bus_arbiter u_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .vb_n    (vb_n),
        .busak   (busak),
        .busrq_n (busrq_n),
        .dma_cs  (dma_cs),
        .xfer    (xfer_if.ctrl)
    );

    dma_slot_seq #(.DW(DW)) u_seq (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .hbd_n (hbd_n),
        .din   (din),
        .we    (ram_we),
        .wdata (ram_wdata),
        .xfer  (xfer_if.seq)
    );

    dma_addr_counter #(.LEN_LOG2(LEN_LOG2)) u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .xfer  (xfer_if.cnt)
    );

    obj_ram #(.DW(DW), .LEN_LOG2(LEN_LOG2)) u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (xfer_if.addr),
        .wdata (ram_wdata),
        .raddr (obj_raddr),
        .rdata (obj_rdata)
    );

endmodule

`default_nettype wire

// File: sim/tb_popeye_obj_dma.sv
// frame-table testbench for the object DMA with LEN_LOG2 = 6 for 64-byte copies
// the CPU object area is a testbench array and din follows dm while dma_cs is high
`timescale 1ns/10ps
`default_nettype none

module tb_popeye_obj_dma
    import dma_cfg_pkg::*;
;

    localparam int LEN_LOG2   = 6;
    localparam int LEN        = 1 << LEN_LOG2;
    localparam int NUM_FRAMES = 4;
    // bound on one copy since pauses can stretch it about three times
    localparam int COPY_LIMIT = 4000;

    typedef struct packed {
        logic [7:0] pat_off;
        int         hb_period;
        int         hb_low;
        int         ack_dly;
        bit         hold_ack;
    } frame_row_t;

    logic                clk;
    logic                rst_n;
    logic                cen;
    logic                vb_n;
    logic                hbd_n;
    logic                busak;
    logic [DEF_DW-1:0]   din;
    logic [LEN_LOG2-1:0] obj_raddr;
    logic                busrq_n;
    logic                dma_cs;
    logic [LEN_LOG2-1:0] dm;
    logic [DEF_DW-1:0]   obj_rdata;

    // base random bytes and the CPU object area of the current frame
    logic [DEF_DW-1:0]   rnd_mem [0:LEN-1];
    logic [DEF_DW-1:0]   cpu_mem [0:LEN-1];
    frame_row_t          frames  [0:NUM_FRAMES-1];

    integer              seed;
    int                  hb_period;
    int                  hb_low;
    int                  cyc;
    logic                lo_prev;
    logic [LEN_LOG2-1:0] dm_prev;

    popeye_obj_dma #(.DW(DEF_DW), .LEN_LOG2(LEN_LOG2)) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .vb_n      (vb_n),
        .hbd_n     (hbd_n),
        .busak     (busak),
        .din       (din),
        .obj_raddr (obj_raddr),
        .busrq_n   (busrq_n),
        .dma_cs    (dma_cs),
        .dm        (dm),
        .obj_rdata (obj_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // reporting
    // ========================================================================

    task automatic report_error(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "wait timed out");
    endtask

    // ========================================================================
    // one clock step with all inputs changed on the falling edge
    // ========================================================================

    task next_cycle();
        logic                lo_now;
        logic [LEN_LOG2-1:0] dm_next;
        @(negedge clk);
        // hbd_n value that the last rising edge saw
        lo_now  = ~hbd_n;
        dm_next = dm_prev + 1'b1;
        // two blocked edges in a row mean any step in flight has landed
        if (rst_n && lo_now && lo_prev) begin
            assert (dm == dm_prev)
                else report_error($sformatf("dm moved from %0d to %0d during hblank",
                                            dm_prev, dm));
        end
        // address walks up one byte at a time
        if (rst_n && dma_cs) begin
            assert (dm == dm_prev || dm == dm_next)
                else report_error($sformatf("dm jumped from %0d to %0d", dm_prev, dm));
        end
        lo_prev = lo_now;
        dm_prev = dm;
        cen     = ~cen;
        hbd_n   = (hb_period == 0) ? 1'b1 : ((cyc % hb_period) >= hb_low);
        if (dma_cs) begin
            din = cpu_mem[dm];
        end
        cyc = cyc + 1;
    endtask

    // ========================================================================
    // one frame of request, grant, copy, release and readback
    // ========================================================================

    task run_frame(input int idx);
        int n;
        int i;
        for (i = 0; i < LEN; i++) begin
            cpu_mem[i] = rnd_mem[i] + frames[idx].pat_off;
        end
        hb_period = frames[idx].hb_period;
        hb_low    = frames[idx].hb_low;

        // vblank starts and the request follows on the next edge
        assert (busrq_n === 1'b1) else report_error("request pending before vblank");
        vb_n = 1'b0;
        next_cycle();
        assert (busrq_n === 1'b0 && dma_cs === 1'b0)
            else report_error("busrq_n not low or dma_cs high after the vb_n fall");
        vb_n = 1'b1;

        // CPU takes its time to acknowledge
        for (n = 0; n < frames[idx].ack_dly; n++) begin
            next_cycle();
            assert (busrq_n === 1'b0 && dma_cs === 1'b0)
                else report_error("dma_cs high or request lost before busak");
        end
        busak = 1'b1;
        next_cycle();
        assert (dma_cs === 1'b1) else report_error("dma_cs not high one cycle after busak");

        // copy runs until the request is dropped
        n = 0;
        while (busrq_n !== 1'b1) begin
            assert (dma_cs === 1'b1) else report_error("dma_cs fell during the copy");
            next_cycle();
            n = n + 1;
            if (n >= COPY_LIMIT) begin
                report_timeout("busrq_n never returned high, copy did not finish");
            end
        end

        if (!frames[idx].hold_ack) begin
            busak = 1'b0;
            next_cycle();
            assert (dma_cs === 1'b0) else report_error("dma_cs still high after busak fell");
        end else begin
            // CPU keeps the grant and a vblank edge in between must be ignored
            for (n = 0; n < 12; n++) begin
                if (n == 3) begin
                    vb_n = 1'b0;
                end
                if (n == 6) begin
                    vb_n = 1'b1;
                end
                next_cycle();
                assert (dma_cs === 1'b1 && busrq_n === 1'b1)
                    else report_error("bus state changed while busak was held");
            end
            busak = 1'b0;
            next_cycle();
            assert (dma_cs === 1'b0) else report_error("dma_cs still high after held busak fell");
        end

        for (n = 0; n < 3; n++) begin
            next_cycle();
            assert (busrq_n === 1'b1) else report_error("request issued without a vblank edge");
        end

        // video side reads back the whole buffer
        for (i = 0; i < LEN; i++) begin
            obj_raddr = LEN_LOG2'(i);
            next_cycle();
            assert (obj_rdata === cpu_mem[i])
                else report_error($sformatf("frame %0d addr %0d: got %02h, expected %02h",
                                            idx, i, obj_rdata, cpu_mem[i]));
        end
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        int i;
        int f;
        rst_n     = 1'b0;
        cen       = 1'b0;
        vb_n      = 1'b1;
        hbd_n     = 1'b1;
        busak     = 1'b0;
        din       = '0;
        obj_raddr = '0;
        hb_period = 0;
        hb_low    = 0;
        cyc       = 0;
        lo_prev   = 1'b0;
        dm_prev   = '0;
        seed      = 32'h9222_30eb;

        // offset, hblank period, hblank low cycles, ack delay, hold busak
        frames[0] = '{8'h00, 0, 0, 0, 1'b0};
        frames[1] = '{8'h5a, 16, 6, 3, 1'b0};
        frames[2] = '{8'h33, 40, 25, 7, 1'b1};
        frames[3] = '{8'hc1, 9, 4, 1, 1'b0};

        for (i = 0; i < LEN; i++) begin
            rnd_mem[i] = DEF_DW'($random(seed));
        end

        for (i = 0; i < 8; i++) begin
            next_cycle();
        end
        rst_n = 1'b1;

        // idle bus with no vblank yet
        for (i = 0; i < 10; i++) begin
            next_cycle();
            assert (busrq_n === 1'b1 && dma_cs === 1'b0)
                else report_error("bus activity before the first vblank");
        end

        for (f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/dma_cfg_pkg.sv
verilog/dma_types_pkg.sv
verilog/dma_xfer_if.sv
verilog/dma_bus_arbiter.sv
verilog/dma_slot_seq.sv
verilog/dma_addr_counter.sv
verilog/obj_ram.sv
verilog/popeye_obj_dma.sv
sim/tb_popeye_obj_dma.sv

// File: Bender.yml
package:
  name: popeye_obj_dma

sources:
  - files:
      - verilog/dma_cfg_pkg.sv
      - verilog/dma_types_pkg.sv
      - verilog/dma_xfer_if.sv
      - verilog/dma_bus_arbiter.sv
      - verilog/dma_slot_seq.sv
      - verilog/dma_addr_counter.sv
      - verilog/obj_ram.sv
      - verilog/popeye_obj_dma.sv
  - target: simulation
    files:
      - sim/tb_popeye_obj_dma.sv
